//--- linear_search_top.f
source/search_pkg.sv
source/apb_map_pkg.sv
source/feistel_cipher.sv
source/search_ctrl.sv
source/result_arbiter.sv
source/apb_regs.sv
source/linear_search_top.sv
bench/tb_clock_gen.sv
bench/linear_search_tb.sv

//--- Makefile
# Verilator build and run for the linear search subsystem

VERILATOR ?= verilator
TOP       ?= linear_search_tb
FILELIST  ?= linear_search_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/linear_search_tb.sv
`timescale 1ns/1ps
`default_nettype none

module linear_search_tb
    import search_pkg::*, apb_map_pkg::*;
();

    localparam int          ROUNDS     = 4;
    localparam int          COUNT_W    = 6;
    localparam int          NUM_ENG    = 2;
    localparam logic [63:0] KEY        = 64'h3A94_C1F0_5E27_8DB6;
    localparam logic [63:0] MASK_I     = 64'h0000_0010_4200_0021;  // Bits inside the plaintext
    localparam logic [63:0] MASK_O     = 64'h8001_0400_0020_0104;
    localparam int          COUNTS     = 1 << COUNT_W;
    localparam int          POLL_LIMIT = COUNTS * (ROUNDS + 4);
    localparam int          RUN_LIMIT  = 6 * COUNTS * (ROUNDS + 4) + 2000;

    // PRESENT S-box in input order
    localparam logic [3:0] SBOX_TABLE [16] = '{
        4'hC, 4'h5, 4'h6, 4'hB, 4'h9, 4'h0, 4'hA, 4'hD,
        4'h3, 4'hE, 4'hF, 4'h8, 4'h4, 4'h7, 4'h1, 4'h2
    };

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    paddr_t      paddr;
    pdata_t      pwdata;
    pdata_t      prdata;
    logic        pready;
    logic        pslverr;

    int          error_count;
    int          cycle_count;
    integer      seed;
    logic [31:0] region_of [NUM_ENG];  // Region last loaded into each engine

    tb_clock_gen #(
        .PERIOD_NS    (4),
        .RESET_CYCLES (3)
    ) clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    linear_search_top #(
        .ROUNDS      (ROUNDS),
        .COUNT_W     (COUNT_W),
        .KEY         (KEY),
        .MASK_I      (MASK_I),
        .MASK_O      (MASK_O),
        .NUM_ENGINES (NUM_ENG)
    ) linear_search_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // Reference cipher round: S-box per nibble, rotate left by 3
    function automatic logic [31:0] round_f(input logic [31:0] x, input logic [31:0] k);
        logic [31:0] t;
        logic [31:0] s;
        t = x ^ k;
        for (int n = 0; n < 8; n++) begin
            s[n*4 +: 4] = SBOX_TABLE[t[n*4 +: 4]];
        end
        return (s << 3) | (s >> 29);
    endfunction

    function automatic logic [63:0] encrypt_ref(input logic [63:0] pt);
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] rk;
        logic [31:0] prev_l;
        l = pt[63:32];
        r = pt[31:0];
        for (int i = 0; i < ROUNDS; i++) begin
            rk     = (i % 2 == 0) ? KEY[63:32] : KEY[31:0];
            prev_l = l;
            l      = r;
            r      = prev_l ^ round_f(r, rk);
        end
        return {l, r};  // No final swap
    endfunction

    function automatic logic [63:0] make_plaintext(input logic [31:0] region, input int count);
        return ({32'h0, region} << COUNT_W) | 64'(count);
    endfunction

    // Hits over the whole region
    function automatic logic [31:0] count_hits(input logic [31:0] region);
        logic [63:0] pt;
        logic [63:0] ct;
        logic [31:0] n;
        n = '0;
        for (int c = 0; c < COUNTS; c++) begin
            pt = make_plaintext(region, c);
            ct = encrypt_ref(pt);
            if ((^(pt & MASK_I)) == (^(ct & MASK_O))) begin
                n = n + 32'd1;
            end
        end
        return n;
    endfunction

    function automatic paddr_t reg_addr(input int e, input paddr_t off);
        return paddr_t'(e * int'(ENGINE_STRIDE) + int'(off));
    endfunction

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", RUN_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
            error_count++;
        end
    endtask

    // Setup then access phase, outputs sampled mid-cycle
    task automatic write_reg(input paddr_t addr, input pdata_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        compare_value("pready", 32'h1, 32'(pready));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input paddr_t addr, output pdata_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1 penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        compare_value("pready", 32'h1, 32'(pready));
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic expect_reg(input int e, input paddr_t off, input string name,
                              input logic [31:0] expected);
        pdata_t got;
        logic   err;
        read_reg(reg_addr(e, off), got, err);
        compare_value($sformatf("eng%0d %s pslverr", e, name), 32'h0, 32'(err));
        compare_value($sformatf("eng%0d %s", e, name), expected, got);
    endtask

    task automatic send_cmd(input int e, input cmd_t c);
        logic err;
        write_reg(reg_addr(e, REG_CMD), pdata_t'(c), err);
        compare_value($sformatf("eng%0d CMD write pslverr", e), 32'h0, 32'(err));
    endtask

    task automatic load_region(input int e, input logic [31:0] region);
        logic err;
        write_reg(reg_addr(e, REG_REGION), region, err);
        compare_value($sformatf("eng%0d REGION write pslverr", e), 32'h0, 32'(err));
        expect_reg(e, REG_REGION, "REGION", region);
        send_cmd(e, SET_REGION);
        region_of[e] = region;
    endtask

    task automatic wait_result(input int e);
        pdata_t st;
        logic   err;
        int     t0;
        t0 = cycle_count;
        st = '0;
        while (!st[1]) begin
            if (cycle_count - t0 > POLL_LIMIT) begin
                $display("Engine %0d never finished within %0d cycles", e, POLL_LIMIT);
                error_count++;
                return;
            end
            read_reg(reg_addr(e, REG_STATUS), st, err);
        end
    endtask

    task automatic check_search(input int e);
        logic [63:0] ct;
        ct = encrypt_ref(make_plaintext(region_of[e], COUNTS - 1));
        expect_reg(e, REG_HITS, "HITS", count_hits(region_of[e]));
        expect_reg(e, REG_CT_LO, "CT_LO", ct[31:0]);
        expect_reg(e, REG_CT_HI, "CT_HI", ct[63:32]);
    endtask

    initial begin
        logic [31:0] r0;
        logic [31:0] r1;
        logic [63:0] ct;
        pdata_t      got;
        logic        err;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        error_count = 0;
        seed        = 32'hb6af;
        @(posedge rst_n);

        // Reset values
        for (int e = 0; e < NUM_ENG; e++) begin
            expect_reg(e, REG_STATUS, "STATUS", 32'h0);
            expect_reg(e, REG_CMD, "CMD", 32'(NONE));
        end

        // Single full search on engine 0
        r0 = $random(seed);
        load_region(0, r0);
        send_cmd(0, START);
        wait_result(0);
        check_search(0);
        expect_reg(0, REG_CMD, "CMD", 32'(START));

        // Both engines at once, records must not mix
        r0 = $random(seed);
        r1 = $random(seed);
        while (r1 == r0) r1 = $random(seed);
        load_region(0, r0);
        load_region(1, r1);
        send_cmd(0, START);
        send_cmd(1, START);
        wait_result(0);
        wait_result(1);
        check_search(0);
        check_search(1);

        // Test mode steps on engine 1
        send_cmd(1, TEST);
        for (int step = 0; step < 6; step++) begin
            if (step > 0) send_cmd(1, ADVANCE);
            wait_result(1);
            ct = encrypt_ref(make_plaintext(region_of[1], step));
            expect_reg(1, REG_HITS, "HITS", 32'(step));  // Count, not a total
            expect_reg(1, REG_CT_LO, "CT_LO", ct[31:0]);
            expect_reg(1, REG_CT_HI, "CT_HI", ct[63:32]);
            expect_reg(1, REG_STATUS, "STATUS", 32'h6);
        end
        send_cmd(0, ADVANCE);  // Idle engine ignores it
        expect_reg(0, REG_CMD, "CMD", 32'(START));
        send_cmd(1, RESTART);
        expect_reg(1, REG_STATUS, "STATUS", 32'h0);

        // Abort a running search, then run it again
        r0 = $random(seed);
        load_region(0, r0);
        send_cmd(0, START);
        repeat (20) @(posedge clk);
        expect_reg(0, REG_STATUS, "STATUS", 32'h1);
        send_cmd(0, RESTART);
        expect_reg(0, REG_STATUS, "STATUS", 32'h0);
        expect_reg(0, REG_CMD, "CMD", 32'(RESTART));
        send_cmd(0, START);
        wait_result(0);
        check_search(0);

        // Decode errors
        read_reg(reg_addr(2, REG_STATUS), got, err);
        compare_value("eng2 STATUS read pslverr", 32'h1, 32'(err));
        write_reg(reg_addr(2, REG_CMD), pdata_t'(SET_REGION), err);
        compare_value("eng2 CMD write pslverr", 32'h1, 32'(err));
        read_reg(reg_addr(0, 8'h18), got, err);
        compare_value("eng0 offset 0x18 pslverr", 32'h1, 32'(err));
        expect_reg(0, REG_CMD, "CMD", 32'(START));

        $display("Checks finished with %0d errors", error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- source/linear_search_top.sv
`timescale 1ns/1ps
`default_nettype none

module linear_search_top
    import search_pkg::*, apb_map_pkg::*;
#(
    parameter int     ROUNDS      = 8,
    parameter int     COUNT_W     = 16,
    parameter block_t KEY         = 64'h0F1E_2D3C_4B5A_6978,
    parameter block_t MASK_I      = 64'h2104_0080_0000_0000,
    parameter block_t MASK_O      = 64'h0000_0000_2104_0080,
    parameter int     NUM_ENGINES = 2
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   psel,
    input  logic   penable,
    input  logic   pwrite,
    input  paddr_t paddr,
    input  pdata_t pwdata,
    output pdata_t prdata,
    output logic   pready,
    output logic   pslverr
);

    localparam int IDX_W = (NUM_ENGINES > 1) ? $clog2(NUM_ENGINES) : 1;

    logic [NUM_ENGINES-1:0] cmd_valid;
    cmd_t                   cmd [NUM_ENGINES];
    region_t                region [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] busy;
    logic [NUM_ENGINES-1:0] test_mode;
    cmd_t                   last_cmd [NUM_ENGINES];
    logic [NUM_ENGINES-1:0] res_req;
    logic [NUM_ENGINES-1:0] res_grant;
    hits_t                  res_hits [NUM_ENGINES];
    block_t                 res_ct [NUM_ENGINES];
    logic                   wr_en;
    logic [IDX_W-1:0]       wr_engine;
    hits_t                  wr_hits;
    block_t                 wr_ct;

    apb_regs #(
        .NUM_ENGINES (NUM_ENGINES),
        .IDX_W       (IDX_W)
    ) apb_regs_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .region    (region),
        .busy      (busy),
        .test_mode (test_mode),
        .last_cmd  (last_cmd),
        .wr_en     (wr_en),
        .wr_engine (wr_engine),
        .wr_hits   (wr_hits),
        .wr_ct     (wr_ct)
    );

    for (genvar e = 0; e < NUM_ENGINES; e++) begin : g_engine
        search_ctrl #(
            .ROUNDS  (ROUNDS),
            .COUNT_W (COUNT_W),
            .KEY     (KEY),
            .MASK_I  (MASK_I),
            .MASK_O  (MASK_O)
        ) search_ctrl_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd_valid (cmd_valid[e]),
            .cmd       (cmd[e]),
            .region    (region[e]),
            .busy      (busy[e]),
            .test_mode (test_mode[e]),
            .last_cmd  (last_cmd[e]),
            .res_req   (res_req[e]),
            .res_grant (res_grant[e]),
            .res_hits  (res_hits[e]),
            .res_ct    (res_ct[e])
        );
    end

    result_arbiter #(
        .NUM_ENGINES (NUM_ENGINES),
        .IDX_W       (IDX_W)
    ) result_arbiter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (res_req),
        .hits      (res_hits),
        .ct        (res_ct),
        .grant     (res_grant),
        .wr_en     (wr_en),
        .wr_engine (wr_engine),
        .wr_hits   (wr_hits),
        .wr_ct     (wr_ct)
    );

endmodule

`default_nettype wire

//--- source/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs
    import search_pkg::*, apb_map_pkg::*;
#(
    parameter int NUM_ENGINES = 2,
    parameter int IDX_W       = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  paddr_t                 paddr,
    input  pdata_t                 pwdata,
    output pdata_t                 prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic [NUM_ENGINES-1:0] cmd_valid,
    output cmd_t                   cmd [NUM_ENGINES],
    output region_t                region [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0] busy,
    input  logic [NUM_ENGINES-1:0] test_mode,
    input  cmd_t                   last_cmd [NUM_ENGINES],
    input  logic                   wr_en,
    input  logic [IDX_W-1:0]       wr_engine,
    input  hits_t                  wr_hits,
    input  block_t                 wr_ct
);

    paddr_t                 eng_sel;
    paddr_t                 offset;
    logic                   eng_ok;
    logic                   off_ok;
    logic                   access;
    logic                   wr_access;
    logic [NUM_ENGINES-1:0] accepted;
    logic [NUM_ENGINES-1:0] res_valid;
    hits_t                  res_hits [NUM_ENGINES];
    block_t                 res_ct [NUM_ENGINES];

    // Mirrors the engine's acceptance rules
    function automatic logic cmd_accepted(input cmd_t c, input logic bsy, input logic tm);
        case (c)
            RESTART:                 return 1'b1;
            SET_REGION, START, TEST: return !bsy && !tm;
            ADVANCE:                 return !bsy && tm;
            default:                 return 1'b0;
        endcase
    endfunction

    assign eng_sel   = paddr / ENGINE_STRIDE;
    assign offset    = paddr % ENGINE_STRIDE;
    assign eng_ok    = eng_sel < paddr_t'(NUM_ENGINES);
    assign access    = psel && penable;
    assign wr_access = access && pwrite && eng_ok && off_ok;
    assign pready    = 1'b1;                          // No wait states
    assign pslverr   = access && !(eng_ok && off_ok);

    always_comb begin
        case (offset)
            REG_CMD, REG_REGION, REG_STATUS, REG_HITS, REG_CT_LO, REG_CT_HI: off_ok = 1'b1;
            default: off_ok = 1'b0;
        endcase
    end

    always_comb begin
        for (int e = 0; e < NUM_ENGINES; e++) begin
            cmd_valid[e] = wr_access && offset == REG_CMD && eng_sel == paddr_t'(e);
            cmd[e]       = cmd_t'(pwdata[2:0]);
            accepted[e]  = cmd_valid[e] && cmd_accepted(cmd[e], busy[e], test_mode[e]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int e = 0; e < NUM_ENGINES; e++) begin
                region[e] <= '0;
            end
        end else begin
            for (int e = 0; e < NUM_ENGINES; e++) begin
                if (wr_access && offset == REG_REGION && eng_sel == paddr_t'(e)) begin
                    region[e] <= pwdata;
                end
            end
        end
    end

    // Shared result bank
    always_ff @(posedge clk) begin
        if (wr_en) begin
            res_hits[wr_engine] <= wr_hits;
            res_ct[wr_engine]   <= wr_ct;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= '0;
        end else begin
            for (int e = 0; e < NUM_ENGINES; e++) begin
                if (accepted[e]) begin  // Any new command retires the old result
                    res_valid[e] <= 1'b0;
                end else if (wr_en && wr_engine == IDX_W'(e)) begin
                    res_valid[e] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        prdata = '0;
        for (int e = 0; e < NUM_ENGINES; e++) begin
            if (eng_sel == paddr_t'(e)) begin
                case (offset)
                    REG_CMD:    prdata = pdata_t'(last_cmd[e]);
                    REG_REGION: prdata = region[e];
                    REG_STATUS: prdata = pdata_t'({test_mode[e], res_valid[e], busy[e]});
                    REG_HITS:   prdata = res_hits[e];
                    REG_CT_LO:  prdata = res_ct[e][31:0];
                    REG_CT_HI:  prdata = res_ct[e][63:32];
                    default:    prdata = '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- source/result_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module result_arbiter
    import search_pkg::*;
#(
    parameter int NUM_ENGINES = 2,
    parameter int IDX_W       = 1
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [NUM_ENGINES-1:0] req,
    input  hits_t                  hits [NUM_ENGINES],
    input  block_t                 ct [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0] grant,
    output logic                   wr_en,
    output logic [IDX_W-1:0]       wr_engine,
    output hits_t                  wr_hits,
    output block_t                 wr_ct
);

    logic [IDX_W-1:0] ptr_q;  // Highest priority this cycle

    always_comb begin
        int idx;
        grant     = '0;
        wr_en     = 1'b0;
        wr_engine = '0;
        for (int i = 0; i < NUM_ENGINES; i++) begin
            idx = int'(ptr_q) + i;
            if (idx >= NUM_ENGINES) begin
                idx = idx - NUM_ENGINES;
            end
            if (!wr_en && req[idx]) begin  // First requester from the pointer on
                wr_en     = 1'b1;
                wr_engine = IDX_W'(idx);
            end
        end
        if (wr_en) begin
            grant[wr_engine] = 1'b1;
        end
        wr_hits = hits[wr_engine];
        wr_ct   = ct[wr_engine];
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (wr_en) begin
            ptr_q <= (int'(wr_engine) == NUM_ENGINES - 1) ? '0 : wr_engine + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/search_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module search_ctrl
    import search_pkg::*;
#(
    parameter int     ROUNDS  = 8,
    parameter int     COUNT_W = 16,
    parameter block_t KEY     = '0,
    parameter block_t MASK_I  = '0,
    parameter block_t MASK_O  = '0
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_valid,
    input  cmd_t    cmd,
    input  region_t region,
    output logic    busy,
    output logic    test_mode,
    output cmd_t    last_cmd,
    output logic    res_req,
    input  logic    res_grant,
    output hits_t   res_hits,
    output block_t  res_ct
);

    typedef enum logic [2:0] {
        IDLE,
        RUN_ENC,
        RUN_NEXT,
        POST_FINAL,
        TEST_ENC,
        TEST_POST,
        TEST_HOLD
    } state_t;

    state_t             state;
    region_t            region_q;
    logic [COUNT_W-1:0] count_q;
    hits_t              hits_q;
    logic               enc_start;
    logic               enc_done;
    logic               ct_ready;
    logic               is_hit;
    block_t             plaintext;
    block_t             ciphertext;

    assign plaintext = block_t'({region_q, count_q});  // Region above the count
    assign is_hit    = (^(plaintext & MASK_I)) == (^(ciphertext & MASK_O));
    assign ct_ready  = enc_done && !enc_start;          // Ignore a done left over from an abort

    assign busy      = (state != IDLE) && (state != TEST_HOLD);
    assign test_mode = (state == TEST_ENC) || (state == TEST_POST) || (state == TEST_HOLD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            count_q   <= '0;
            hits_q    <= '0;
            enc_start <= 1'b0;
            res_req   <= 1'b0;
            last_cmd  <= NONE;
        end else if (cmd_valid && cmd == RESTART) begin  // Abort from any state
            state     <= IDLE;
            hits_q    <= '0;
            enc_start <= 1'b0;
            res_req   <= 1'b0;
            last_cmd  <= RESTART;
        end else begin
            enc_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_valid) begin
                        case (cmd)
                            SET_REGION: last_cmd <= SET_REGION;
                            START: begin
                                count_q   <= '0;
                                hits_q    <= '0;
                                enc_start <= 1'b1;
                                state     <= RUN_ENC;
                                last_cmd  <= START;
                            end
                            TEST: begin
                                count_q   <= '0;
                                enc_start <= 1'b1;
                                state     <= TEST_ENC;
                                last_cmd  <= TEST;
                            end
                            default: ;
                        endcase
                    end
                end
                RUN_ENC: begin
                    if (ct_ready) begin
                        if (is_hit) begin
                            hits_q <= hits_q + 1'b1;
                        end
                        if (&count_q) begin  // Region exhausted
                            res_req <= 1'b1;
                            state   <= POST_FINAL;
                        end else begin
                            state <= RUN_NEXT;
                        end
                    end
                end
                RUN_NEXT: begin
                    count_q   <= count_q + 1'b1;
                    enc_start <= 1'b1;
                    state     <= RUN_ENC;
                end
                POST_FINAL: begin
                    if (res_grant) begin
                        res_req <= 1'b0;
                        state   <= IDLE;
                    end
                end
                TEST_ENC: begin
                    if (ct_ready) begin
                        res_req <= 1'b1;
                        state   <= TEST_POST;
                    end
                end
                TEST_POST: begin
                    if (res_grant) begin
                        res_req <= 1'b0;
                        state   <= TEST_HOLD;
                    end
                end
                TEST_HOLD: begin
                    if (cmd_valid && cmd == ADVANCE) begin  // Step one plaintext
                        count_q   <= count_q + 1'b1;
                        enc_start <= 1'b1;
                        state     <= TEST_ENC;
                        last_cmd  <= ADVANCE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && cmd_valid && cmd == SET_REGION) begin
            region_q <= region;
        end
        if (ct_ready && state == RUN_ENC) begin
            res_hits <= hits_q + hits_t'(is_hit);  // Total including this plaintext
            res_ct   <= ciphertext;
        end else if (ct_ready && state == TEST_ENC) begin
            res_hits <= hits_t'(count_q);          // Test record carries the count
            res_ct   <= ciphertext;
        end
    end

    feistel_cipher #(
        .ROUNDS (ROUNDS),
        .KEY    (KEY)
    ) cipher_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (enc_start),
        .plaintext  (plaintext),
        .ciphertext (ciphertext),
        .done       (enc_done)
    );

endmodule

`default_nettype wire

//--- source/feistel_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module feistel_cipher
    import search_pkg::*;
#(
    parameter int     ROUNDS = 8,
    parameter block_t KEY    = '0
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  block_t plaintext,
    output block_t ciphertext,
    output logic   done
);

    localparam int RW = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;

    // PRESENT S-box, entry 0 in the low nibble
    localparam logic [63:0] SBOX = 64'h2174_8FE3_DA09_B65C;

    half_t         left_q;
    half_t         right_q;
    half_t         round_key;
    logic [RW-1:0] round_q;
    logic          running;

    // S-box on every nibble, then rotate left by 3
    function automatic half_t round_f(input half_t x, input half_t k);
        half_t t;
        half_t s;
        t = x ^ k;
        for (int n = 0; n < 8; n++) begin
            s[n*4 +: 4] = SBOX[{t[n*4 +: 4], 2'b00} +: 4];
        end
        return {s[28:0], s[31:29]};
    endfunction

    assign round_key  = round_q[0] ? KEY[31:0] : KEY[63:32];  // Odd rounds use the low word
    assign ciphertext = {left_q, right_q};                     // No final swap

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            running <= 1'b0;
            done    <= 1'b0;
            round_q <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                round_q <= '0;
            end else if (running) begin
                round_q <= round_q + 1'b1;
                if (round_q == RW'(ROUNDS - 1)) begin  // Last round
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            {left_q, right_q} <= plaintext;
        end else if (running) begin
            left_q  <= right_q;
            right_q <= left_q ^ round_f(right_q, round_key);
        end
    end

endmodule

`default_nettype wire

//--- source/apb_map_pkg.sv
`default_nettype none

// APB bus types and the per-engine register map
package apb_map_pkg;

    typedef logic [7:0]  paddr_t;
    typedef logic [31:0] pdata_t;

    parameter paddr_t ENGINE_STRIDE = 8'h20;   // One window per engine

    parameter paddr_t REG_CMD    = 8'h00;
    parameter paddr_t REG_REGION = 8'h04;
    parameter paddr_t REG_STATUS = 8'h08;      // bit0 busy, bit1 result_valid, bit2 test_mode
    parameter paddr_t REG_HITS   = 8'h0C;
    parameter paddr_t REG_CT_LO  = 8'h10;
    parameter paddr_t REG_CT_HI  = 8'h14;

endpackage

`default_nettype wire

//--- source/search_pkg.sv
`default_nettype none

// Types shared by the search engines and the register block
package search_pkg;

    typedef logic [63:0] block_t;   // Plaintext or ciphertext
    typedef logic [31:0] half_t;    // Feistel half, also a round key
    typedef logic [31:0] region_t;  // Region as written over APB
    typedef logic [31:0] hits_t;

    // Engine command codes
    typedef enum logic [2:0] {
        NONE       = 3'd0,
        SET_REGION = 3'd1,
        START      = 3'd2,
        TEST       = 3'd3,
        RESTART    = 3'd4,
        ADVANCE    = 3'd5
    } cmd_t;

endpackage

`default_nettype wire
